//--- vlog.f
rtl/rv_isa_pkg.sv
rtl/frontend_pkg.sv
rtl/fetch_stage.sv
rtl/instr_queue.sv
rtl/predecode_stage.sv
rtl/frontend_top.sv
sim/imem_responder.sv
sim/frontend_tb.sv

//--- sim/frontend_tb.sv
// Testbench for the RV32I front end with a stimulus table, random back-pressure and a scoreboard.
`timescale 1ns/10ps
`default_nettype none

module frontend_tb;

	localparam int NUM_TESTS       = 5;
	localparam int RECORDS         = 12;    // Checked after start or redirect.
	localparam int CYCLES_PER_TEST = 200;   // Watchdog budget.
	localparam int STALL_CYCLES    = 100;   // Long enough to fill every buffer.
	localparam logic [1:0] READY_ALWAYS = 2'd0;
	localparam logic [1:0] READY_RANDOM = 2'd1;
	localparam logic [1:0] READY_STALL  = 2'd2;   // Low first, then high.

	logic                 clk;
	logic                 arst_n;
	logic                 redirect;
	rv_isa_pkg::xlen_t    redirect_pc;
	logic                 mem_req;
	rv_isa_pkg::xlen_t    mem_addr;
	logic                 mem_ack;
	rv_isa_pkg::xlen_t    mem_rdata;
	logic                 dec_valid;
	logic                 dec_ready;
	rv_isa_pkg::xlen_t    dec_pc;
	frontend_pkg::class_e dec_class;
	logic [4:0]           dec_rd;
	logic [4:0]           dec_rs1;
	logic [4:0]           dec_rs2;
	rv_isa_pkg::xlen_t    dec_imm;
	logic [1:0]           ack_rnd;                     // Responder delays.
	logic [1:0]           drop_rnd;
	logic                 ready_rnd;                   // Back-pressure bit.
	logic                 proto_error;
	logic [31:0]          lfsr_state = 32'h0000_f98d;

	string                test_name    [NUM_TESTS];
	int                   redir_cycle  [NUM_TESTS];     // Zero means none.
	rv_isa_pkg::xlen_t    redir_target [NUM_TESTS];
	logic [1:0]           ready_mode   [NUM_TESTS];
	int                   n_tests = 0;

	frontend_top i_frontend_top (
		.CLK         (clk),
		.arst_n      (arst_n),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.dec_valid   (dec_valid),
		.dec_ready   (dec_ready),
		.dec_pc      (dec_pc),
		.dec_class   (dec_class),
		.dec_rd      (dec_rd),
		.dec_rs1     (dec_rs1),
		.dec_rs2     (dec_rs2),
		.dec_imm     (dec_imm)
	);

	imem_responder i_imem (
		.clk        (clk),
		.arst_n     (arst_n),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ack    (mem_ack),
		.mem_rdata  (mem_rdata),
		.ack_delay  (ack_rnd),
		.drop_delay (drop_rnd),
		.violation  (proto_error)
	);

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic take_bit(output logic b);
		b          = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	endtask

	// R, I with negative imm12, then other, rotating over the word index.
	function automatic logic [31:0] program_word(input int k);
		logic [6:0] a;
		logic [6:0] opc;
		a = k[6:0];
		case (k % 3)
			0: program_word = {a, ~a[4:0], a[4:0], a[2:0], a[4:0] + 5'd1, rv_isa_pkg::OP};
			1: begin
				case ((k / 3) % 3)
					0:       opc = rv_isa_pkg::OP_IMM;
					1:       opc = rv_isa_pkg::LOAD;
					default: opc = rv_isa_pkg::JALR;
				endcase
				program_word = {1'b1, a[3:0], a, a[6:2], a[2:0], ~a[4:0], opc};
			end
			default: program_word = {7'd0, a, 11'h2ab, a[3] ? 7'b1101111 : 7'b0110111};
		endcase
	endfunction

	task automatic load_program();
		for (int k = 0; k < 128; k++) begin
			i_imem.rom[k] = program_word(k);
		end
	endtask

	task automatic add_test(input string name, input int cyc, input rv_isa_pkg::xlen_t pc,
		input logic [1:0] mode);
		test_name[n_tests]    = name;
		redir_cycle[n_tests]  = cyc;
		redir_target[n_tests] = pc;
		ready_mode[n_tests]   = mode;
		n_tests++;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", what, exp, act);
			$display("tests failed");
			$fatal(1, "mismatch in %s", what);
		end
	endtask

	// Expected record from the word at pc, split by raw bit positions.
	task automatic score_record(input int t, input rv_isa_pkg::xlen_t pc);
		logic [31:0] w;
		logic [1:0]  cls;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		w   = program_word(int'(pc[8:2]));
		cls = frontend_pkg::CLS_OTHER;
		rd  = 5'd0;
		rs1 = 5'd0;
		rs2 = 5'd0;
		imm = 32'd0;
		if (w[6:0] == rv_isa_pkg::OP) begin
			cls = frontend_pkg::CLS_REG;
			rd  = w[11:7];
			rs1 = w[19:15];
			rs2 = w[24:20];
		end else if (w[6:0] == rv_isa_pkg::OP_IMM || w[6:0] == rv_isa_pkg::LOAD ||
			w[6:0] == rv_isa_pkg::JALR) begin
			cls = frontend_pkg::CLS_IMM;
			rd  = w[11:7];
			rs1 = w[19:15];
			imm = {{20{w[31]}}, w[31:20]};            // Sign from bit 31.
		end
		check_value($sformatf("%s dec_pc", test_name[t]), pc, dec_pc);
		check_value($sformatf("%s dec_class at %h", test_name[t], pc), cls, dec_class);
		check_value($sformatf("%s dec_rd at %h", test_name[t], pc), rd, dec_rd);
		check_value($sformatf("%s dec_rs1 at %h", test_name[t], pc), rs1, dec_rs1);
		check_value($sformatf("%s dec_rs2 at %h", test_name[t], pc), rs2, dec_rs2);
		check_value($sformatf("%s dec_imm at %h", test_name[t], pc), imm, dec_imm);
	endtask

	task automatic run_test(input int t);
		int                cyc;
		int                got;
		logic              redirected;
		logic              seen_req;
		logic              redir;
		logic              ready;
		rv_isa_pkg::xlen_t exp_pc;
		cyc        = 0;
		got        = 0;
		redirected = 1'b0;
		seen_req   = 1'b0;
		exp_pc     = frontend_pkg::RESET_PC;
		@(negedge clk);
		arst_n    = 1'b0;
		redirect  = 1'b0;
		dec_ready = 1'b0;
		repeat (3) @(negedge clk);
		check_value($sformatf("%s mem_req in reset", test_name[t]), 0, mem_req);
		check_value($sformatf("%s dec_valid in reset", test_name[t]), 0, dec_valid);
		arst_n = 1'b1;
		while (got < RECORDS || (redir_cycle[t] != 0 && !redirected)) begin
			@(negedge clk);
			cyc++;
			if (!seen_req && mem_req) begin
				check_value($sformatf("%s first mem_addr", test_name[t]),
					frontend_pkg::RESET_PC, mem_addr);
				seen_req = 1'b1;
			end
			// Redirect only while a request is out, so its word must be dropped.
			redir = redir_cycle[t] != 0 && !redirected && cyc >= redir_cycle[t] && mem_req;
			case (ready_mode[t])
				READY_ALWAYS: ready = 1'b1;
				READY_RANDOM: ready = ready_rnd;
				default:      ready = cyc > STALL_CYCLES;
			endcase
			if (redir) ready = 1'b0;               // No handshake on the flush edge.
			redirect    = redir;
			redirect_pc = redir ? redir_target[t] : '0;
			dec_ready   = ready;
			if (redir) begin
				exp_pc     = redir_target[t];
				got        = 0;
				redirected = 1'b1;
			end else if (dec_valid && ready) begin
				score_record(t, exp_pc);           // Taken at the next rising edge.
				exp_pc = exp_pc + frontend_pkg::PC_STEP;
				got++;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;                    // 100 ns period.
	end

	// Every LFSR bit is drawn here, five per falling edge, in fixed order.
	always @(negedge clk) begin : draw_bits
		logic [4:0] bits;
		logic       b;
		for (int i = 0; i < 5; i++) begin
			take_bit(b);
			bits[i] = b;
		end
		ack_rnd   <= bits[1:0];
		drop_rnd  <= bits[3:2];
		ready_rnd <= bits[4];
	end

	initial begin
		wait (proto_error === 1'b1);
		$display("tests failed");
		$fatal(1, "instruction memory protocol violation");
	end

	initial begin
		repeat (CYCLES_PER_TEST * NUM_TESTS) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles",
			CYCLES_PER_TEST * NUM_TESTS);
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		arst_n      = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		dec_ready   = 1'b0;
		ack_rnd     = '0;
		drop_rnd    = '0;
		ready_rnd   = 1'b0;
		load_program();
		add_test("in_order",          0,  32'h0000_0000, READY_ALWAYS);
		add_test("random_ready",      0,  32'h0000_0000, READY_RANDOM);
		add_test("queue_full",        0,  32'h0000_0000, READY_STALL);
		add_test("redirect_inflight", 25, 32'h0000_0100, READY_RANDOM);
		add_test("redirect_stalled",  20, 32'h0000_0040, READY_STALL);
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/imem_responder.sv
// Instruction memory model answering four-phase requests after random delays and checking the protocol.
`timescale 1ns/10ps
`default_nettype none

module imem_responder (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        mem_req,
	input  logic [31:0] mem_addr,
	output logic        mem_ack,
	output logic [31:0] mem_rdata,
	input  logic [1:0]  ack_delay,     // Extra cycles before ack rises.
	input  logic [1:0]  drop_delay,    // Extra cycles before ack falls.
	output logic        violation      // Sticky protocol error.
);

	localparam logic [1:0] IDLE = 2'd0;   // Waiting for mem_req.
	localparam logic [1:0] WAIT = 2'd1;   // Counting down to ack.
	localparam logic [1:0] HELD = 2'd2;   // Ack high until req falls.
	localparam logic [1:0] DROP = 2'd3;   // Counting down to ack low.

	logic [31:0] rom [128];    // Program words, by address / 4.
	logic [1:0]  phase;
	logic [1:0]  count;        // Remaining delay.
	logic [31:0] req_addr;     // Address seen when req rose.

	initial begin
		mem_ack   = 1'b0;
		mem_rdata = '0;
		violation = 1'b0;
		phase     = IDLE;
		count     = '0;
		req_addr  = '0;
	end

	always @(negedge clk) begin
		if (!arst_n) begin
			phase   <= IDLE;
			mem_ack <= 1'b0;
		end else begin
			if (mem_req && phase != IDLE && mem_addr != req_addr) begin
				$display("protocol error: mem_addr moved from %h to %h during a request",
					req_addr, mem_addr);
				violation <= 1'b1;
			end
			if (mem_req && phase == DROP) begin
				$display("protocol error: mem_req rose again before mem_ack fell");
				violation <= 1'b1;
			end
			case (phase)
				IDLE: begin
					if (mem_req) begin
						req_addr <= mem_addr;      // Phase 1 seen.
						count    <= ack_delay;
						phase    <= WAIT;
					end
				end
				WAIT: begin
					if (count == 2'd0) begin
						mem_ack   <= 1'b1;         // Phase 2.
						mem_rdata <= rom[req_addr[8:2]];
						phase     <= HELD;
					end else begin
						count <= count - 2'd1;
					end
				end
				HELD: begin
					if (!mem_req) begin
						count <= drop_delay;       // Phase 3 seen.
						phase <= DROP;
					end
				end
				default: begin
					if (count == 2'd0) begin
						mem_ack <= 1'b0;           // Phase 4.
						phase   <= IDLE;
					end else begin
						count <= count - 2'd1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/frontend_top.sv
// RV32I front end top level connecting fetch, instruction queue and predecode.
`timescale 1ns/10ps
`default_nettype none

module frontend_top (
	input  logic                 CLK,
	input  logic                 arst_n,
	input  logic                 redirect,      // Branch or trap restart.
	input  rv_isa_pkg::xlen_t    redirect_pc,
	output logic                 mem_req,       // Instruction memory port.
	output rv_isa_pkg::xlen_t    mem_addr,
	input  logic                 mem_ack,
	input  rv_isa_pkg::xlen_t    mem_rdata,
	output logic                 dec_valid,     // Decoded record port.
	input  logic                 dec_ready,
	output rv_isa_pkg::xlen_t    dec_pc,
	output frontend_pkg::class_e dec_class,
	output logic [4:0]           dec_rd,
	output logic [4:0]           dec_rs1,
	output logic [4:0]           dec_rs2,
	output rv_isa_pkg::xlen_t    dec_imm
);

	logic              push;         // Fetch to queue.
	rv_isa_pkg::xlen_t push_pc;
	rv_isa_pkg::xlen_t push_instr;
	logic              full;
	logic              pop;          // Queue to predecode.
	rv_isa_pkg::xlen_t head_pc;
	rv_isa_pkg::xlen_t head_instr;
	logic              empty;

	fetch_stage i_fetch (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.push        (push),
		.push_pc     (push_pc),
		.push_instr  (push_instr),
		.full        (full)
	);

	// Redirect empties the queue and the slot.
	instr_queue i_queue (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.flush      (redirect),
		.push       (push),
		.push_pc    (push_pc),
		.push_instr (push_instr),
		.full       (full),
		.pop        (pop),
		.head_pc    (head_pc),
		.head_instr (head_instr),
		.empty      (empty)
	);

	predecode_stage i_predecode (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.flush      (redirect),
		.empty      (empty),
		.head_pc    (head_pc),
		.head_instr (head_instr),
		.pop        (pop),
		.dec_valid  (dec_valid),
		.dec_ready  (dec_ready),
		.dec_pc     (dec_pc),
		.dec_class  (dec_class),
		.dec_rd     (dec_rd),
		.dec_rs1    (dec_rs1),
		.dec_rs2    (dec_rs2),
		.dec_imm    (dec_imm)
	);

endmodule

`default_nettype wire

//--- rtl/predecode_stage.sv
// Predecode stage that pops the queue head, splits the word into fields and holds the output slot.
`timescale 1ns/10ps
`default_nettype none

module predecode_stage (
	input  logic                 CLK,
	input  logic                 arst_n,
	input  logic                 flush,        // Drop the slot record.
	input  logic                 empty,        // Queue has nothing.
	input  rv_isa_pkg::xlen_t    head_pc,
	input  rv_isa_pkg::xlen_t    head_instr,
	output logic                 pop,
	output logic                 dec_valid,    // Slot holds a record.
	input  logic                 dec_ready,    // Consumer takes it.
	output rv_isa_pkg::xlen_t    dec_pc,
	output frontend_pkg::class_e dec_class,
	output logic [4:0]           dec_rd,
	output logic [4:0]           dec_rs1,
	output logic [4:0]           dec_rs2,
	output rv_isa_pkg::xlen_t    dec_imm
);

	rv_isa_pkg::instr_u   word;      // Head word, both views.
	frontend_pkg::class_e cls;       // Decoded class.
	logic [4:0]           rd;
	logic [4:0]           rs1;
	logic [4:0]           rs2;
	rv_isa_pkg::xlen_t    imm;       // Sign-extended imm12.

	assign word = head_instr;

	// Field split by opcode.
	always_comb begin
		cls = frontend_pkg::CLS_OTHER;   // Unknown opcode, all zero.
		rd  = 5'd0;
		rs1 = 5'd0;
		rs2 = 5'd0;
		imm = '0;
		case (word.r.opcode)
			rv_isa_pkg::OP: begin
				cls = frontend_pkg::CLS_REG;
				rd  = word.r.rd;
				rs1 = word.r.rs1;
				rs2 = word.r.rs2;
			end
			rv_isa_pkg::OP_IMM,
			rv_isa_pkg::LOAD,
			rv_isa_pkg::JALR: begin
				cls = frontend_pkg::CLS_IMM;
				rd  = word.i.rd;
				rs1 = word.i.rs1;
				imm = {{20{word.i.imm12[11]}}, word.i.imm12};  // Bit 31 copied up.
			end
			default: begin
				cls = frontend_pkg::CLS_OTHER;
			end
		endcase
	end

	// Refill when the slot is free or drains this cycle.
	assign pop = (!dec_valid || dec_ready) && !empty;

	// Slot occupancy.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
		end else if (flush) begin
			dec_valid <= 1'b0;        // Old path record.
		end else if (pop) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0;        // Taken, nothing behind it.
		end
	end

	// Slot payload.
	always_ff @(posedge CLK) begin
		if (pop) begin
			dec_pc    <= head_pc;
			dec_class <= cls;
			dec_rd    <= rd;
			dec_rs1   <= rs1;
			dec_rs2   <= rs2;
			dec_imm   <= imm;
		end
	end

endmodule

`default_nettype wire

//--- rtl/instr_queue.sv
// Instruction queue, a ring buffer of pc and word pairs with wrap-bit pointers and flush.
`timescale 1ns/10ps
`default_nettype none

module instr_queue (
	input  logic              CLK,
	input  logic              arst_n,
	input  logic              flush,       // Drop all entries.
	input  logic              push,
	input  rv_isa_pkg::xlen_t push_pc,
	input  rv_isa_pkg::xlen_t push_instr,
	output logic              full,
	input  logic              pop,
	output rv_isa_pkg::xlen_t head_pc,     // From read pointer.
	output rv_isa_pkg::xlen_t head_instr,
	output logic              empty
);

	logic [frontend_pkg::QUEUE_AW:0]   rd_ptr;   // MSB is the wrap bit.
	logic [frontend_pkg::QUEUE_AW:0]   wr_ptr;
	logic [frontend_pkg::QUEUE_AW-1:0] rd_idx;   // Storage index.
	logic [frontend_pkg::QUEUE_AW-1:0] wr_idx;
	logic                              do_push;
	logic                              do_pop;

	rv_isa_pkg::xlen_t pc_mem    [frontend_pkg::QUEUE_DEPTH];  // Pc per slot.
	rv_isa_pkg::xlen_t instr_mem [frontend_pkg::QUEUE_DEPTH];  // Word per slot.

	assign rd_idx = rd_ptr[frontend_pkg::QUEUE_AW-1:0];
	assign wr_idx = wr_ptr[frontend_pkg::QUEUE_AW-1:0];

	assign empty = (rd_ptr == wr_ptr);   // Same lap, same slot.
	// Same slot, one lap apart.
	assign full  = (rd_idx == wr_idx) &&
		(rd_ptr[frontend_pkg::QUEUE_AW] != wr_ptr[frontend_pkg::QUEUE_AW]);

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Pointers.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else if (flush) begin
			rd_ptr <= '1;                        // Equal pointers mean empty.
			wr_ptr <= '1;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage.
	always_ff @(posedge CLK) begin
		if (do_push) begin
			pc_mem[wr_idx]    <= push_pc;
			instr_mem[wr_idx] <= push_instr;
		end
	end

	assign head_pc    = pc_mem[rd_idx];       // Read is combinational.
	assign head_instr = instr_mem[rd_idx];

	// The fetch side offers a push only with room.
	a_no_push_full: assert property (@(posedge CLK) disable iff (!arst_n)
		push |-> !full)
		else $error("queue: push while full");

	// The predecode side pops only a present entry.
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (!arst_n)
		pop |-> !empty)
		else $error("queue: pop while empty");

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
// Fetch stage with pc counter, four-phase memory requester and one-word return buffer.
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
	input  logic              CLK,
	input  logic              arst_n,
	input  logic              redirect,        // Restart request.
	input  rv_isa_pkg::xlen_t redirect_pc,     // Restart address.
	output logic              mem_req,         // Phase 1 and 3.
	output rv_isa_pkg::xlen_t mem_addr,        // Held while mem_req.
	input  logic              mem_ack,         // Phase 2 and 4.
	input  rv_isa_pkg::xlen_t mem_rdata,       // Valid with mem_ack.
	output logic              push,            // To the queue.
	output rv_isa_pkg::xlen_t push_pc,
	output rv_isa_pkg::xlen_t push_instr,
	input  logic              full             // Queue has no room.
);

	rv_isa_pkg::xlen_t pc;          // Next address to fetch.
	rv_isa_pkg::xlen_t start_pc;    // Address used by a new request.
	logic              ack_wait;    // Req dropped, ack still high.
	logic              discard;     // In-flight word is stale.
	logic              launch;      // Raise mem_req at this edge.
	logic              capture;     // Keep the returned word.
	logic              buf_valid;   // Return buffer occupied.
	rv_isa_pkg::xlen_t buf_pc;      // Pc of buffered word.
	rv_isa_pkg::xlen_t buf_instr;   // Buffered word.

	assign start_pc = redirect ? redirect_pc : pc;  // Redirect wins.

	// Idle, ack low and nowhere to park data otherwise.
	assign launch  = !mem_req && !ack_wait && !mem_ack && !buf_valid;
	assign capture = mem_req && mem_ack && !discard && !redirect;

	// Handshake FSM, pc and address.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pc       <= frontend_pkg::RESET_PC;
			mem_addr <= frontend_pkg::RESET_PC;
			mem_req  <= 1'b0;
			ack_wait <= 1'b0;
			discard  <= 1'b0;
		end else begin
			if (launch) begin
				mem_addr <= start_pc;                        // Latched for the whole request.
				pc       <= start_pc + frontend_pkg::PC_STEP;
			end else if (redirect) begin
				pc <= redirect_pc;
			end
			if (launch) begin
				mem_req <= 1'b1;                             // Phase 1.
			end else if (mem_req && mem_ack) begin
				mem_req <= 1'b0;                             // Phase 3.
			end
			if (mem_req && mem_ack) begin
				ack_wait <= 1'b1;
			end else if (ack_wait && !mem_ack) begin
				ack_wait <= 1'b0;                            // Phase 4 seen.
			end
			if (mem_req && mem_ack) begin
				discard <= 1'b0;                             // Stale word dropped here.
			end else if (mem_req && redirect) begin
				discard <= 1'b1;
			end
		end
	end

	// Return buffer control.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			buf_valid <= 1'b0;
		end else if (redirect) begin
			buf_valid <= 1'b0;                               // Old path word.
		end else if (capture) begin
			buf_valid <= 1'b1;
		end else if (push) begin
			buf_valid <= 1'b0;                               // Moved into the queue.
		end
	end

	// Buffer payload.
	always_ff @(posedge CLK) begin
		if (capture) begin
			buf_pc    <= mem_addr;
			buf_instr <= mem_rdata;
		end
	end

	assign push       = buf_valid && !full;   // Only offered with room.
	assign push_pc    = buf_pc;
	assign push_instr = buf_instr;

	// Address held through the request until the memory answers.
	a_addr_stable: assert property (@(posedge CLK) disable iff (!arst_n)
		mem_req && !mem_ack |=> $stable(mem_addr))
		else $error("fetch: mem_addr changed during a request");

	// No new request while the previous ack is still high.
	a_req_after_ack: assert property (@(posedge CLK) disable iff (!arst_n)
		$rose(mem_req) |-> !mem_ack)
		else $error("fetch: request raised with ack high");

endmodule

`default_nettype wire

//--- rtl/frontend_pkg.sv
// Front end package with queue geometry, fetch addresses and predecode classes.
`default_nettype none

package frontend_pkg;

	// Queue geometry.
	localparam int QUEUE_AW    = 2;                 // Index bits.
	localparam int QUEUE_DEPTH = 2 ** QUEUE_AW;     // Four entries.

	// Fetch addressing.
	localparam rv_isa_pkg::xlen_t RESET_PC = 32'h0000_0000;  // First fetch.
	localparam rv_isa_pkg::xlen_t PC_STEP  = 32'd4;          // One word.

	// Predecode class of a record.
	typedef enum logic [1:0] {
		CLS_REG   = 2'd0,                  // OP.
		CLS_IMM   = 2'd1,                  // OP_IMM, LOAD, JALR.
		CLS_OTHER = 2'd2                   // Anything else.
	} class_e;

endpackage

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
// RV32I ISA package with word type, major opcodes and instruction format views.
`default_nettype none

package rv_isa_pkg;

	localparam int XLEN = 32;                  // Base integer width.

	typedef logic [XLEN-1:0] xlen_t;           // Data or address word.

	// Major opcodes seen by the front end.
	typedef enum logic [6:0] {
		OP     = 7'b0110011,                   // Register-register ALU.
		OP_IMM = 7'b0010011,                   // Register-immediate ALU.
		LOAD   = 7'b0000011,                   // Loads, I format.
		JALR   = 7'b1100111                    // Indirect jump, I format.
	} opcode_e;

	// R format, field order as in the encoding.
	typedef struct packed {
		logic [6:0] funct7;                    // Bits 31:25.
		logic [4:0] rs2;                       // Bits 24:20.
		logic [4:0] rs1;                       // Bits 19:15.
		logic [2:0] funct3;                    // Bits 14:12.
		logic [4:0] rd;                        // Bits 11:7.
		logic [6:0] opcode;                    // Bits 6:0.
	} r_fmt_t;

	// I format; imm12 overlays funct7 and rs2 of the R view.
	typedef struct packed {
		logic [11:0] imm12;                    // Signed immediate.
		logic [4:0]  rs1;                      // Base or source register.
		logic [2:0]  funct3;                   // Minor opcode.
		logic [4:0]  rd;                       // Destination.
		logic [6:0]  opcode;                   // Same place as in R.
	} i_fmt_t;

	// One fetched word, read as either format.
	typedef union packed {
		r_fmt_t r;                             // Register view.
		i_fmt_t i;                             // Immediate view.
	} instr_u;

endpackage

`default_nettype wire
